// File: files.f
hdl/ilkn_word_pkg.sv
hdl/ilkn_burst_pkg.sv
hdl/aligned_lanes_if.sv
hdl/lane_deskew.sv
hdl/burst_extract.sv
hdl/flow_calendar.sv
hdl/ilkn_rx_top.sv
verif/ilkn_rx_tb.sv

// File: hdl/aligned_lanes_if.sv
`timescale 1ns/10ps
/*
 * aligned lanes link
 * carries one deskewed stripe per valid strobe from the deskew block
 * to the burst datapath, together with the lock level
 */
interface aligned_lanes_if import ilkn_word_pkg::*; #(
	parameter int NUM_LANES = 4
);

	// lane 0 is first in transmission order
	lane_word_t [NUM_LANES-1:0] words;
	logic [NUM_LANES-1:0] ctrl;

	// one strobe for the whole stripe
	logic valid;

	// level, high while all lanes run aligned
	logic locked;

	modport source (
		output words,
		output ctrl,
		output valid,
		output locked
	);

	modport sink (
		input words,
		input ctrl,
		input valid,
		input locked
	);

endinterface

// File: hdl/burst_extract.sv
`timescale 1ns/10ps
/*
 * burst extract
 * drops framing words, walks burst and idle control words to mark
 * SOP, EOP and channel, checks CRC24 and feeds the flow-control calendar
 */
module burst_extract import ilkn_word_pkg::*, ilkn_burst_pkg::*; #(
	parameter int NUM_LANES = 4
) (
	input  logic                             common_clk,
	input  logic                             rst_n,
	aligned_lanes_if.sink                    aligned,
	output lane_word_t [NUM_LANES-1:0]       out_data,
	output logic [NUM_LANES-1:0]             out_valid,
	output logic [NUM_LANES-1:0]             out_sop,
	output logic [NUM_LANES-1:0]             out_eop,
	output logic [NUM_LANES-1:0][CHAN_W-1:0] out_channel,
	output logic                             crc24_err,
	output logic                             cal_strobe,
	output logic [FLOW_W-1:0]                cal_flow,
	output logic                             cal_reset
);

	// context carried from stripe to stripe
	logic [CRC_W-1:0]  crc_q;
	logic [CHAN_W-1:0] chan_q;
	logic              sop_pend_q;
	logic              prev_data_q;

	// one stripe held back until the following control word shows its EOP
	lane_word_t [NUM_LANES-1:0]       held_data_q;
	logic [NUM_LANES-1:0][CHAN_W-1:0] held_chan_q;
	logic [NUM_LANES-1:0]             held_valid_q;
	logic [NUM_LANES-1:0]             held_sop_q;
	logic [NUM_LANES-1:0]             held_eop_q;
	logic [NUM_LANES-1:0]             held_last_q;

	// running values while walking the current stripe
	logic [CRC_W-1:0]  crc_v;
	logic [CRC_W-1:0]  crc_chk;
	logic [CHAN_W-1:0] chan_v;
	logic              sop_v;
	logic              prev_v;
	logic [NUM_LANES-1:0] cur_valid;
	logic [NUM_LANES-1:0] cur_sop;
	logic [NUM_LANES-1:0] cur_eop;
	logic [NUM_LANES-1:0] cur_last;
	logic [NUM_LANES-1:0][CHAN_W-1:0] cur_chan;
	logic [NUM_LANES-1:0] held_eop_add;
	logic              stripe_live;
	logic              crc_bad;
	logic              cal_hit;
	logic [FLOW_W-1:0] cal_flow_v;
	logic              cal_reset_v;

	////////////////////
	// stripe walk

	always_comb begin
		crc_v        = crc_q;
		crc_chk      = '0;
		chan_v       = chan_q;
		sop_v        = sop_pend_q;
		prev_v       = prev_data_q;
		cur_valid    = '0;
		cur_sop      = '0;
		cur_eop      = '0;
		cur_last     = '0;
		cur_chan     = '0;
		held_eop_add = '0;
		stripe_live  = 1'b0;
		crc_bad      = 1'b0;
		cal_hit      = 1'b0;
		cal_flow_v   = '0;
		cal_reset_v  = 1'b0;
		// lanes are visited in transmission order, lane 0 first
		for (int l = 0; l < NUM_LANES; l++) begin
			cur_chan[l] = chan_v;
			if (aligned.ctrl[l] && aligned.words[l][WORD_KIND_BIT]) begin
				// burst or idle control word closes the CRC span
				stripe_live = 1'b1;
				crc_chk = crc24_next(crc_v,
					{aligned.words[l][63:CRC_W], {CRC_W{1'b0}}});
				if (crc_chk != aligned.words[l][CRC_W-1:0]) begin
					crc_bad = 1'b1;
				end
				crc_v = CRC24_INIT;
				// EOP lands on the data word right before, here or in the held stripe
				if (aligned.words[l][EOP_BIT] && prev_v) begin
					if (|cur_last) begin
						cur_eop = cur_eop | cur_last;
					end else begin
						held_eop_add = held_last_q;
					end
				end
				if (ctrl_kind_e'(aligned.words[l][CTRL_KIND_BIT]) == CTRL_BURST) begin
					chan_v = aligned.words[l][CHAN_LSB +: CHAN_W];
					sop_v  = aligned.words[l][SOP_BIT];
				end
				prev_v = 1'b0;
				// a later lane overwrites, so the highest control word wins
				cal_hit     = 1'b1;
				cal_flow_v  = aligned.words[l][FLOW_LSB +: FLOW_W];
				cal_reset_v = aligned.words[l][RESET_CAL_BIT];
			end else if (!aligned.ctrl[l]) begin
				// data word of the current burst
				stripe_live  = 1'b1;
				crc_v        = crc24_next(crc_v, aligned.words[l]);
				cur_valid[l] = 1'b1;
				cur_sop[l]   = sop_v;
				cur_chan[l]  = chan_v;
				sop_v        = 1'b0;
				prev_v       = 1'b1;
				cur_last     = '0;
				cur_last[l]  = 1'b1;
			end
			// framing words fall through and are gone
		end
	end

	////////////////////
	// registers

	always_ff @(posedge common_clk or negedge rst_n) begin
		if (!rst_n) begin
			crc_q        <= CRC24_INIT;
			chan_q       <= '0;
			sop_pend_q   <= 1'b0;
			prev_data_q  <= 1'b0;
			held_valid_q <= '0;
			held_sop_q   <= '0;
			held_eop_q   <= '0;
			held_last_q  <= '0;
			out_valid    <= '0;
			out_sop      <= '0;
			out_eop      <= '0;
			crc24_err    <= 1'b0;
			cal_strobe   <= 1'b0;
		end else begin
			crc24_err  <= aligned.valid & crc_bad;
			cal_strobe <= aligned.valid & cal_hit;
			out_valid  <= '0;
			out_sop    <= '0;
			out_eop    <= '0;
			if (!aligned.locked) begin
				// lost lanes, the burst context starts over after relock
				crc_q       <= CRC24_INIT;
				sop_pend_q  <= 1'b0;
				prev_data_q <= 1'b0;
			end else if (aligned.valid && stripe_live) begin
				crc_q        <= crc_v;
				chan_q       <= chan_v;
				sop_pend_q   <= sop_v;
				prev_data_q  <= prev_v;
				// release the held stripe with its EOP settled
				out_valid    <= held_valid_q;
				out_sop      <= held_sop_q;
				out_eop      <= held_eop_q | held_eop_add;
				held_valid_q <= cur_valid;
				held_sop_q   <= cur_sop;
				held_eop_q   <= cur_eop;
				held_last_q  <= cur_last;
			end
		end
	end

	// payload side, qualified by the flags above
	always_ff @(posedge common_clk) begin
		if (aligned.valid && stripe_live) begin
			out_data    <= held_data_q;
			out_channel <= held_chan_q;
			held_data_q <= aligned.words;
			held_chan_q <= cur_chan;
		end
		if (aligned.valid && cal_hit) begin
			cal_flow  <= cal_flow_v;
			cal_reset <= cal_reset_v;
		end
	end

endmodule

// File: hdl/flow_calendar.sv
`timescale 1ns/10ps
/*
 * flow-control calendar
 * writes the 16 flow bits of each control word into the next page
 */
module flow_calendar import ilkn_burst_pkg::*; #(
	parameter int CALENDAR_PAGES = 4
) (
	input  logic                               common_clk,
	input  logic                               rst_n,
	input  logic                               cal_strobe,
	input  logic [FLOW_W-1:0]                  cal_flow,
	input  logic                               cal_reset,
	output logic [FLOW_W*CALENDAR_PAGES-1:0]   calendar
);

	localparam int PG_W = (CALENDAR_PAGES > 1) ? $clog2(CALENDAR_PAGES) : 1;

	// page 0 sits in the low 16 bits of the calendar
	logic [CALENDAR_PAGES-1:0][FLOW_W-1:0] pages;
	logic [PG_W-1:0] page_ptr;
	logic [PG_W-1:0] wr_page;
	logic [PG_W-1:0] ptr_after;

	// the reset-calendar bit forces this word onto page 0
	assign wr_page   = cal_reset ? '0 : page_ptr;
	// step past the page just written, wrapping after the last one
	assign ptr_after = (wr_page == PG_W'(CALENDAR_PAGES - 1)) ? '0 : wr_page + 1'b1;

	always_ff @(posedge common_clk or negedge rst_n) begin
		if (!rst_n) begin
			pages    <= '0;
			page_ptr <= '0;
		end else if (cal_strobe) begin
			pages[wr_page] <= cal_flow;
			page_ptr       <= ptr_after;
		end
	end

	assign calendar = pages;

endmodule

// File: hdl/ilkn_burst_pkg.sv
/*
 * burst layer package
 * field positions of burst and idle control words, the control kind
 * and the CRC24 step shared by the datapath and the reference model
 */
package ilkn_burst_pkg;

	// bit 62 of a burst-layer control word
	typedef enum logic {
		CTRL_IDLE  = 1'b0,
		CTRL_BURST = 1'b1
	} ctrl_kind_e;

	localparam int CTRL_KIND_BIT = 62;

	// start of packet, applies to the next data word
	localparam int SOP_BIT = 61;

	// end of packet, applies to the data word just before this control word
	localparam int EOP_BIT = 60;

	// restarts the flow-control calendar at page 0
	localparam int RESET_CAL_BIT = 56;

	// 16 flow-control bits at 55:40
	localparam int FLOW_LSB = 40;
	localparam int FLOW_W   = 16;

	// channel number at 39:32
	localparam int CHAN_LSB = 32;
	localparam int CHAN_W   = 8;

	// CRC24 sits in the low bits of the control word
	localparam int CRC_W = 24;
	localparam logic [CRC_W-1:0] CRC24_POLY = 24'h328B63;
	localparam logic [CRC_W-1:0] CRC24_INIT = 24'hFFFFFF;

	// fold one 64-bit word into the running CRC, msb first
	// the control word is folded with its CRC field already zeroed
	function automatic logic [CRC_W-1:0] crc24_next(
		input logic [CRC_W-1:0] crc,
		input logic [63:0] word
	);
		logic [CRC_W-1:0] c;
		logic fb;
		c = crc;
		for (int i = 63; i >= 0; i--) begin
			fb = c[CRC_W-1] ^ word[i];
			c = {c[CRC_W-2:0], 1'b0};
			if (fb) begin
				c = c ^ CRC24_POLY;
			end
		end
		return c;
	endfunction

endpackage

// File: hdl/ilkn_rx_top.sv
`timescale 1ns/10ps
/*
 * Interlaken-style receive top
 * lane deskew, burst extraction and the flow-control calendar on one clock
 */
module ilkn_rx_top import ilkn_word_pkg::*, ilkn_burst_pkg::*; #(
	parameter int NUM_LANES      = 4,
	parameter int DESKEW_DEPTH   = 8,
	parameter int CALENDAR_PAGES = 4
) (
	input  logic                             common_clk,
	input  logic                             rst_n,
	// lanes arrive word-locked and descrambled, each with its own skew
	input  lane_word_t [NUM_LANES-1:0]       rx_data,
	input  logic [NUM_LANES-1:0]             rx_ctrl,
	input  logic [NUM_LANES-1:0]             rx_valid,
	output logic                             locked,
	output logic                             overflow,
	output lane_word_t [NUM_LANES-1:0]       out_data,
	output logic [NUM_LANES-1:0]             out_valid,
	output logic [NUM_LANES-1:0]             out_sop,
	output logic [NUM_LANES-1:0]             out_eop,
	output logic [NUM_LANES-1:0][CHAN_W-1:0] out_channel,
	output logic                             crc24_err,
	output logic [FLOW_W*CALENDAR_PAGES-1:0] calendar
);

	aligned_lanes_if #(.NUM_LANES(NUM_LANES)) aligned ();

	// calendar feed out of the burst datapath
	logic              cal_strobe;
	logic [FLOW_W-1:0] cal_flow;
	logic              cal_reset;

	assign locked = aligned.locked;

	lane_deskew #(
		.NUM_LANES    (NUM_LANES),
		.DESKEW_DEPTH (DESKEW_DEPTH)
	) i_lane_deskew (
		.common_clk (common_clk),
		.rst_n      (rst_n),
		.rx_data    (rx_data),
		.rx_ctrl    (rx_ctrl),
		.rx_valid   (rx_valid),
		.overflow   (overflow),
		.aligned    (aligned)
	);

	burst_extract #(
		.NUM_LANES (NUM_LANES)
	) i_burst_extract (
		.common_clk  (common_clk),
		.rst_n       (rst_n),
		.aligned     (aligned),
		.out_data    (out_data),
		.out_valid   (out_valid),
		.out_sop     (out_sop),
		.out_eop     (out_eop),
		.out_channel (out_channel),
		.crc24_err   (crc24_err),
		.cal_strobe  (cal_strobe),
		.cal_flow    (cal_flow),
		.cal_reset   (cal_reset)
	);

	flow_calendar #(
		.CALENDAR_PAGES (CALENDAR_PAGES)
	) i_flow_calendar (
		.common_clk (common_clk),
		.rst_n      (rst_n),
		.cal_strobe (cal_strobe),
		.cal_flow   (cal_flow),
		.cal_reset  (cal_reset),
		.calendar   (calendar)
	);

endmodule

// File: hdl/ilkn_word_pkg.sv
/*
 * lane word package
 * layout of a 64-bit lane word, the framing-layer word types and the
 * lane states used while deskewing
 */
package ilkn_word_pkg;

	// one lane payload word, the control flag travels beside it
	typedef logic [63:0] lane_word_t;

	// on a control word this bit splits the two layers
	// set means burst or idle control, clear means framing control
	localparam int WORD_KIND_BIT = 63;

	// framing type sits in a 4-bit field starting here
	localparam int FRAME_TYPE_LSB = 58;

	// framing-layer word types
	// only sync matters to the receiver, the rest are dropped after deskew
	typedef enum logic [3:0] {
		FRAME_SYNC        = 4'h1,
		FRAME_SCRAM_STATE = 4'h2,
		FRAME_SKIP        = 4'h3,
		FRAME_DIAG        = 4'h4
	} frame_type_e;

	// per-lane progress towards alignment
	// a lane hunts for sync, waits for its peers, then runs aligned
	typedef enum logic [1:0] {
		LANE_HUNT,
		LANE_WAIT_PEERS,
		LANE_ALIGNED
	} lane_state_e;

	// true for a framing word of sync type
	// the caller still has to qualify it with the lane control flag
	function automatic logic is_sync_word(input lane_word_t w);
		return (w[WORD_KIND_BIT] == 1'b0) &&
			(frame_type_e'(w[FRAME_TYPE_LSB +: 4]) == FRAME_SYNC);
	endfunction

endpackage

// File: hdl/lane_deskew.sv
`timescale 1ns/10ps
/*
 * lane deskew
 * per-lane FIFOs that line up all lanes on their framing sync words and
 * then release whole stripes, with lock and overflow tracking
 */
module lane_deskew import ilkn_word_pkg::*; #(
	parameter int NUM_LANES    = 4,
	parameter int DESKEW_DEPTH = 8
) (
	input  logic                       common_clk,
	input  logic                       rst_n,
	input  lane_word_t [NUM_LANES-1:0] rx_data,
	input  logic [NUM_LANES-1:0]       rx_ctrl,
	input  logic [NUM_LANES-1:0]       rx_valid,
	output logic                       overflow,
	aligned_lanes_if.source            aligned
);

	localparam int PTR_W = $clog2(DESKEW_DEPTH);
	localparam int CNT_W = $clog2(DESKEW_DEPTH + 1);

	// lane FIFO storage, word and control flag side by side
	lane_word_t fifo_mem [NUM_LANES][DESKEW_DEPTH];
	logic       fifo_ctl [NUM_LANES][DESKEW_DEPTH];

	logic [PTR_W-1:0] wr_ptr [NUM_LANES];
	logic [PTR_W-1:0] rd_ptr [NUM_LANES];
	logic [CNT_W-1:0] cnt    [NUM_LANES];
	lane_state_e      lane_state [NUM_LANES];

	lane_word_t [NUM_LANES-1:0] head_word;
	logic [NUM_LANES-1:0] head_ctl;
	logic [NUM_LANES-1:0] head_sync;
	logic [NUM_LANES-1:0] in_sync;
	logic [NUM_LANES-1:0] wr_en;
	logic [NUM_LANES-1:0] full;
	logic [NUM_LANES-1:0] nonempty;
	logic [NUM_LANES-1:0] waiting;
	logic pop;
	logic misalign;
	logic ovf;
	logic flush;
	logic locked_q;
	logic valid_q;
	lane_word_t [NUM_LANES-1:0] words_q;
	logic [NUM_LANES-1:0] ctrl_q;

	////////////////////
	// lane status

	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			in_sync[l]   = rx_valid[l] & rx_ctrl[l] & is_sync_word(rx_data[l]);
			// a hunting lane throws words away until its sync word shows up
			wr_en[l]     = rx_valid[l] & ((lane_state[l] != LANE_HUNT) | in_sync[l]);
			full[l]      = (cnt[l] == CNT_W'(DESKEW_DEPTH));
			nonempty[l]  = (cnt[l] != '0);
			waiting[l]   = (lane_state[l] == LANE_WAIT_PEERS);
			head_word[l] = fifo_mem[l][rd_ptr[l]];
			head_ctl[l]  = fifo_ctl[l][rd_ptr[l]];
			head_sync[l] = head_ctl[l] & is_sync_word(head_word[l]);
		end
	end

	// once locked, a stripe leaves as soon as every lane has a word
	assign pop      = locked_q & (&nonempty);
	// sync in some lanes but not in others means the lanes slipped
	assign misalign = pop & (|head_sync) & ~(&head_sync);
	// a full lane that pops in the same cycle frees the slot being written
	assign ovf      = |(wr_en & full & ~{NUM_LANES{pop}});
	assign flush    = ovf | misalign;

	// FIFO storage has no reset, the counters tell what is valid
	always_ff @(posedge common_clk) begin
		for (int l = 0; l < NUM_LANES; l++) begin
			if (wr_en[l]) begin
				fifo_mem[l][wr_ptr[l]] <= rx_data[l];
				fifo_ctl[l][wr_ptr[l]] <= rx_ctrl[l];
			end
		end
	end

	////////////////////
	// lock control

	always_ff @(posedge common_clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				lane_state[l] <= LANE_HUNT;
				wr_ptr[l]     <= '0;
				rd_ptr[l]     <= '0;
				cnt[l]        <= '0;
			end
			locked_q <= 1'b0;
			valid_q  <= 1'b0;
			overflow <= 1'b0;
		end else begin
			overflow <= ovf;
			valid_q  <= pop & ~flush;
			if (flush) begin
				// empty every lane and go back to hunting for sync
				locked_q <= 1'b0;
				for (int l = 0; l < NUM_LANES; l++) begin
					lane_state[l] <= LANE_HUNT;
					wr_ptr[l]     <= '0;
					rd_ptr[l]     <= '0;
					cnt[l]        <= '0;
				end
			end else begin
				// every lane holds a sync word at its head, so the heads form a stripe
				if (&waiting) begin
					locked_q <= 1'b1;
				end
				for (int l = 0; l < NUM_LANES; l++) begin
					if (&waiting) begin
						lane_state[l] <= LANE_ALIGNED;
					end else if (lane_state[l] == LANE_HUNT && in_sync[l]) begin
						lane_state[l] <= LANE_WAIT_PEERS;
					end
					if (wr_en[l]) begin
						wr_ptr[l] <= (wr_ptr[l] == PTR_W'(DESKEW_DEPTH - 1)) ? '0 : wr_ptr[l] + 1'b1;
					end
					if (pop) begin
						rd_ptr[l] <= (rd_ptr[l] == PTR_W'(DESKEW_DEPTH - 1)) ? '0 : rd_ptr[l] + 1'b1;
					end
					cnt[l] <= cnt[l] + CNT_W'(wr_en[l]) - CNT_W'(pop);
				end
			end
		end
	end

	// stripe register towards the datapath
	always_ff @(posedge common_clk) begin
		if (pop) begin
			words_q <= head_word;
			ctrl_q  <= head_ctl;
		end
	end

	assign aligned.words  = words_q;
	assign aligned.ctrl   = ctrl_q;
	assign aligned.valid  = valid_q;
	assign aligned.locked = locked_q;

endmodule

// File: run.sh
#!/bin/sh
# build the receive testbench with Verilator and run it
# a $fatal in the run gives a non-zero exit status
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
	--top-module ilkn_rx_tb \
	-f files.f \
	-o ilkn_rx_sim \
	&& ./obj_dir/ilkn_rx_sim \
	|| { echo "simulation did not complete cleanly"; exit 1; }

// File: verif/ilkn_rx_tb.sv
`timescale 1ns/10ps
/*
 * receive testbench
 * skewed lane stimulus in 16-stripe frames, a reference model of the burst
 * layer and calendar, an output comparator and a watchdog
 */
module ilkn_rx_tb import ilkn_word_pkg::*, ilkn_burst_pkg::*; ();

	localparam int NUM_LANES      = 4;
	localparam int DESKEW_DEPTH   = 8;
	localparam int CALENDAR_PAGES = 4;
	localparam int NUM_FRAMES     = 7;
	localparam int NUM_STRIPES    = NUM_FRAMES * 16;
	// this frame carries a lane whose sync word is one stripe late
	localparam int LOST_FRAME     = 3;
	// lanes may lag each other by up to two words less than the FIFO depth
	localparam int MAX_SKEW       = DESKEW_DEPTH - 2;
	localparam int CAL_W          = FLOW_W * CALENDAR_PAGES;

	typedef struct packed {
		lane_word_t        data;
		logic              sop;
		logic              eop;
		logic [CHAN_W-1:0] chan;
	} exp_word_t;

	logic                             common_clk;
	logic                             rst_n;
	lane_word_t [NUM_LANES-1:0]       rx_data;
	logic [NUM_LANES-1:0]             rx_ctrl;
	logic [NUM_LANES-1:0]             rx_valid;
	logic                             locked;
	logic                             overflow;
	lane_word_t [NUM_LANES-1:0]       out_data;
	logic [NUM_LANES-1:0]             out_valid;
	logic [NUM_LANES-1:0]             out_sop;
	logic [NUM_LANES-1:0]             out_eop;
	logic [NUM_LANES-1:0][CHAN_W-1:0] out_channel;
	logic                             crc24_err;
	logic [CAL_W-1:0]                 calendar;

	// transmit stream, one row per stripe, lane 0 first
	lane_word_t tx_word [NUM_STRIPES][NUM_LANES];
	logic       tx_ctrl [NUM_STRIPES][NUM_LANES];
	int         skew [NUM_LANES];
	integer     seed;

	// expected results and the model state that builds them
	// a CRC error is recorded as the number of data words that precede its stripe
	exp_word_t        exp_q [$];
	int               err_q [$];
	logic [CAL_W-1:0] cal_q [$];
	logic [CRC_W-1:0] m_crc;
	logic [CHAN_W-1:0] m_chan;
	logic             m_sop;
	logic             m_prev_data;
	logic [CALENDAR_PAGES-1:0][FLOW_W-1:0] m_pages;
	int               m_page;

	logic seen_lock;
	logic seen_drop;
	logic seen_relock;
	logic cal_pend;
	// data words the DUT has put out so far
	int   n_out;

	ilkn_rx_top #(
		.NUM_LANES      (NUM_LANES),
		.DESKEW_DEPTH   (DESKEW_DEPTH),
		.CALENDAR_PAGES (CALENDAR_PAGES)
	) i_ilkn_rx_top (
		.common_clk  (common_clk),
		.rst_n       (rst_n),
		.rx_data     (rx_data),
		.rx_ctrl     (rx_ctrl),
		.rx_valid    (rx_valid),
		.locked      (locked),
		.overflow    (overflow),
		.out_data    (out_data),
		.out_valid   (out_valid),
		.out_sop     (out_sop),
		.out_eop     (out_eop),
		.out_channel (out_channel),
		.crc24_err   (crc24_err),
		.calendar    (calendar)
	);

	initial begin
		common_clk = 1'b0;
		forever #2 common_clk = ~common_clk;
	end

	// prints the line, then ends the run as failed
	task automatic fail_run(input string line);
		$display("%s", line);
		$display("Done: errors found");
		$fatal(1);
	endtask

	function automatic lane_word_t framing_word(input frame_type_e t);
		lane_word_t w;
		w = '0;
		w[FRAME_TYPE_LSB +: 4] = t;
		return w;
	endfunction

	////////////////////
	// stream generator

	// each frame is a sync stripe, 14 stripes of bursts and one stripe of idle words
	// so every frame closes its last burst and starts from a fresh CRC
	task automatic build_stream();
		logic [CRC_W-1:0] crc;
		logic [31:0] rnd;
		lane_word_t w;
		int left;
		int s;
		int ln;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				tx_word[f*16][l] = framing_word(FRAME_SYNC);
				tx_ctrl[f*16][l] = 1'b1;
			end
			crc = CRC24_INIT;
			left = 0;
			for (int p = 0; p < 60; p++) begin
				s = f*16 + 1 + p/4;
				ln = p % 4;
				if (p == 0 || p >= 56 || left == 0) begin
					w = '0;
					w[WORD_KIND_BIT] = 1'b1;
					w[CTRL_KIND_BIT] = (p < 56);
					w[SOP_BIT] = (p < 56);
					w[EOP_BIT] = (p != 0) && (p <= 56);
					w[RESET_CAL_BIT] = (($unsigned($random(seed)) % 6) == 0);
					rnd = $random(seed);
					w[FLOW_LSB +: FLOW_W] = rnd[15:0];
					w[CHAN_LSB +: CHAN_W] = rnd[23:16];
					// the CRC field is still zero while it is folded in
					w[CRC_W-1:0] = crc24_next(crc, w);
					crc = CRC24_INIT;
					left = 1 + int'($unsigned($random(seed)) % 8);
					tx_ctrl[s][ln] = 1'b1;
				end else begin
					w[63:32] = $random(seed);
					w[31:0] = $random(seed);
					crc = crc24_next(crc, w);
					left--;
					tx_ctrl[s][ln] = 1'b0;
				end
				tx_word[s][ln] = w;
			end
		end
		// a flipped data bit in frame 1 and a flipped CRC bit in frame 5
		tx_word[17][1][5] = ~tx_word[17][1][5];
		tx_word[81][0][0] = ~tx_word[81][0][0];
		// lane 1 sends its sync of frame 3 one stripe late
		tx_word[48][1] = framing_word(FRAME_SKIP);
		tx_word[49][1] = framing_word(FRAME_SYNC);
		tx_ctrl[49][1] = 1'b1;
	endtask

	////////////////////
	// reference model

	// walks one stripe in lane order and appends what the receiver must produce
	function automatic void model_stripe(input int s);
		lane_word_t w;
		lane_word_t cal_w;
		exp_word_t e;
		logic bad;
		logic cal_hit;
		int wr;
		int words_before;
		bad = 1'b0;
		cal_hit = 1'b0;
		cal_w = '0;
		words_before = exp_q.size();
		for (int ln = 0; ln < NUM_LANES; ln++) begin
			w = tx_word[s][ln];
			if (tx_ctrl[s][ln] && w[WORD_KIND_BIT]) begin
				if (crc24_next(m_crc, {w[63:CRC_W], {CRC_W{1'b0}}}) != w[CRC_W-1:0]) begin
					bad = 1'b1;
				end
				m_crc = CRC24_INIT;
				// EOP belongs to the data word right before this control word
				if (w[EOP_BIT] && m_prev_data) begin
					e = exp_q[exp_q.size()-1];
					e.eop = 1'b1;
					exp_q[exp_q.size()-1] = e;
				end
				if (w[CTRL_KIND_BIT]) begin
					m_chan = w[CHAN_LSB +: CHAN_W];
					m_sop = w[SOP_BIT];
				end
				m_prev_data = 1'b0;
				cal_hit = 1'b1;
				cal_w = w;
			end else if (!tx_ctrl[s][ln]) begin
				m_crc = crc24_next(m_crc, w);
				e.data = w;
				e.sop = m_sop;
				e.eop = 1'b0;
				e.chan = m_chan;
				exp_q.push_back(e);
				m_sop = 1'b0;
				m_prev_data = 1'b1;
			end
		end
		// the error shows while the stripe before this one leaves the DUT
		if (bad) begin
			err_q.push_back(words_before);
		end
		// only the highest lane's control word reaches the calendar
		if (cal_hit) begin
			wr = cal_w[RESET_CAL_BIT] ? 0 : m_page;
			m_pages[wr] = cal_w[FLOW_LSB +: FLOW_W];
			m_page = (wr == CALENDAR_PAGES - 1) ? 0 : wr + 1;
			cal_q.push_back(m_pages);
		end
	endfunction

	////////////////////
	// stimulus

	initial begin : drive_lanes
		int idx;
		rst_n = 1'b0;
		rx_data = '0;
		rx_ctrl = '0;
		rx_valid = '0;
		seed = 32'h6106;
		m_crc = CRC24_INIT;
		m_chan = '0;
		m_sop = 1'b0;
		m_prev_data = 1'b0;
		m_pages = '0;
		m_page = 0;
		build_stream();
		for (int s = 0; s < NUM_STRIPES; s++) begin
			if (s / 16 != LOST_FRAME) begin
				model_stripe(s);
			end
		end
		for (int l = 0; l < NUM_LANES; l++) begin
			skew[l] = int'($unsigned($random(seed)) % (MAX_SKEW + 1));
		end
		// the outer lanes span the whole range, so the earliest lane's FIFO runs full
		skew[0] = 0;
		skew[NUM_LANES-1] = MAX_SKEW;
		repeat (8) @(posedge common_clk);
		rst_n <= 1'b1;
		// each lane runs the same stream, delayed by its own skew
		for (int c = 0; c < NUM_STRIPES + MAX_SKEW + 1; c++) begin
			@(posedge common_clk);
			for (int l = 0; l < NUM_LANES; l++) begin
				idx = c - skew[l];
				if (idx >= 0 && idx < NUM_STRIPES) begin
					rx_data[l] <= tx_word[idx][l];
					rx_ctrl[l] <= tx_ctrl[idx][l];
					rx_valid[l] <= 1'b1;
				end else begin
					rx_valid[l] <= 1'b0;
				end
			end
		end
		while (exp_q.size() != 0 || cal_q.size() != 0) begin
			@(posedge common_clk);
		end
		repeat (2) @(posedge common_clk);
		if (err_q.size() == 0 && seen_lock && seen_drop && seen_relock) begin
			$display("Done: no errors");
			$finish;
		end else begin
			assert (err_q.size() == 0)
				else fail_run("crc24_err did not rise for every burst with a bad CRC");
			assert (seen_lock && seen_drop && seen_relock)
				else fail_run("locked did not go through lock, loss of lock and relock");
		end
	end

	////////////////////
	// comparator

	// outputs are sampled on the falling edge, well away from the drive edge
	always @(negedge common_clk) begin : compare_outputs
		exp_word_t e;
		logic [CAL_W-1:0] exp_cal;
		int exp_err;
		if (!rst_n) begin
			seen_lock = 1'b0;
			seen_drop = 1'b0;
			seen_relock = 1'b0;
			cal_pend = 1'b0;
			n_out = 0;
		end else begin
			if (locked && seen_drop) begin
				seen_relock = 1'b1;
			end
			if (!locked && seen_lock) begin
				seen_drop = 1'b1;
			end
			if (locked) begin
				seen_lock = 1'b1;
			end
			// the skew stays within what the lane FIFOs absorb
			assert (!overflow)
				else fail_run($sformatf("[FAIL] %0t overflow expected 0 actual %b",
					$time, overflow));
			if (out_valid != '0) begin
				assert (seen_lock) else fail_run("data left the DUT before it had locked");
			end
			for (int l = 0; l < NUM_LANES; l++) begin
				if (out_valid[l]) begin
					assert (exp_q.size() != 0)
						else fail_run("the DUT put out a data word that was never expected");
					e = exp_q.pop_front();
					n_out++;
					assert (out_data[l] == e.data)
						else fail_run($sformatf("[FAIL] %0t out_data[%0d] expected %h actual %h",
							$time, l, e.data, out_data[l]));
					assert (out_sop[l] == e.sop)
						else fail_run($sformatf("[FAIL] %0t out_sop[%0d] expected %b actual %b",
							$time, l, e.sop, out_sop[l]));
					assert (out_eop[l] == e.eop)
						else fail_run($sformatf("[FAIL] %0t out_eop[%0d] expected %b actual %b",
							$time, l, e.eop, out_eop[l]));
					assert (out_channel[l] == e.chan)
						else fail_run($sformatf("[FAIL] %0t out_channel[%0d] expected %h actual %h",
							$time, l, e.chan, out_channel[l]));
				end
			end
			// the error pulse must fall in the burst that carried the bad CRC
			if (crc24_err) begin
				assert (err_q.size() != 0)
					else fail_run("crc24_err rose for a burst whose CRC was good");
				exp_err = err_q.pop_front();
				assert (n_out == exp_err)
					else fail_run($sformatf(
						"[FAIL] %0t crc24_err expected after word %0d actual after word %0d",
						$time, exp_err, n_out));
			end
			// the calendar follows one cycle after the internal strobe
			if (cal_pend) begin
				assert (cal_q.size() != 0)
					else fail_run("the calendar was written by an unexpected control word");
				exp_cal = cal_q.pop_front();
				assert (calendar == exp_cal)
					else fail_run($sformatf("[FAIL] %0t calendar expected %h actual %h",
						$time, exp_cal, calendar));
			end
			cal_pend = i_ilkn_rx_top.cal_strobe;
		end
	end

	// four clock periods per stripe leave ample room for skew and resync
	initial begin : watchdog
		#(NUM_STRIPES * 4 * 4 + 8 * 4);
		fail_run("timeout, the run hung before all expected output arrived");
	end

endmodule
